// ==== design/icache_pkg.sv ====
`default_nettype none

package icache_pkg;

  // ====================
  // cache geometry
  // ====================
  // two ways only, the replacement state is one bit per set
  localparam int WAY_NUM    = 2;
  localparam int SET_NUM    = 16;
  localparam int LINE_WORDS = 4;

  // ====================
  // address fields
  // ====================
  localparam int ADDR_W = 32;
  localparam int OFS_W  = 4;
  localparam int IDX_W  = 4;
  localparam int TAG_W  = ADDR_W - IDX_W - OFS_W;
  // word select inside a line
  localparam int WSEL_W = OFS_W - 2;

  typedef logic [31:0] word_t;
  // word 0 sits in the low bits
  typedef word_t [LINE_WORDS-1:0] line_t;
  typedef logic [TAG_W-1:0] tag_t;
  typedef logic [IDX_W-1:0] idx_t;

endpackage

`default_nettype wire

// ==== design/icache_sdp_ram.sv ====
`default_nettype none

module icache_sdp_ram import icache_pkg::*; #(
  parameter type payload_t = logic
) (
  input  wire logic     clk,
  input  wire logic     we_i,
  input  wire idx_t     waddr_i,
  input  wire payload_t wdata_i,
  input  wire idx_t     raddr_i,
  output payload_t      rdata_o
);

  payload_t mem [SET_NUM];

  // write-first when both ports hit the same set
  always_ff @(posedge clk) begin
    if (we_i) begin
      mem[waddr_i] <= wdata_i;
    end
    if (we_i && (waddr_i == raddr_i)) begin
      rdata_o <= wdata_i;
    end else begin
      rdata_o <= mem[raddr_i];
    end
  end

endmodule

`default_nettype wire

// ==== design/icache_way.sv ====
`default_nettype none

module icache_way import icache_pkg::*; (
  input  wire logic  clk,
  input  wire logic  rst_n,
  input  wire idx_t  rd_idx_i,
  input  wire tag_t  cmp_tag_i,
  input  wire logic  we_i,
  input  wire idx_t  wr_idx_i,
  input  wire tag_t  wr_tag_i,
  input  wire line_t wr_line_i,
  input  wire logic  inv_we_i,
  input  wire idx_t  inv_idx_i,
  output logic       hit_o,
  output line_t      line_o
);

  logic [SET_NUM-1:0] valid_q;
  idx_t               rd_idx_q;
  tag_t               tag_rd;

  icache_sdp_ram #(.payload_t(tag_t)) u_tag_ram (
    .clk     (clk),
    .we_i    (we_i),
    .waddr_i (wr_idx_i),
    .wdata_i (wr_tag_i),
    .raddr_i (rd_idx_i),
    .rdata_o (tag_rd)
  );

  icache_sdp_ram #(.payload_t(line_t)) u_data_ram (
    .clk     (clk),
    .we_i    (we_i),
    .waddr_i (wr_idx_i),
    .wdata_i (wr_line_i),
    .raddr_i (rd_idx_i),
    .rdata_o (line_o)
  );

  // valid bits, invalidation wins over a fill of the same set
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      valid_q  <= '0;
      rd_idx_q <= '0;
    end else begin
      rd_idx_q <= rd_idx_i;
      if (we_i) begin
        valid_q[wr_idx_i] <= 1'b1;
      end
      if (inv_we_i) begin
        valid_q[inv_idx_i] <= 1'b0;
      end
    end
  end

  // tag ram output lines up with the registered index
  assign hit_o = valid_q[rd_idx_q] && (tag_rd == cmp_tag_i);

endmodule

`default_nettype wire

// ==== design/icache_way_select.sv ====
`default_nettype none

module icache_way_select import icache_pkg::*; (
  input  wire logic                clk,
  input  wire logic                rst_n,
  input  wire logic [WAY_NUM-1:0]  hit_i,
  input  wire line_t [WAY_NUM-1:0] lines_i,
  input  wire idx_t                s1_idx_i,
  input  wire logic [WSEL_W-1:0]   word_sel_i,
  input  wire logic                touch_i,
  input  wire logic                fill_i,
  input  wire logic                fill_way_i,
  output logic                     hit_o,
  output word_t                    word_o,
  output logic                     victim_o
);

  logic [SET_NUM-1:0] repl_q;
  logic               hit_way;
  line_t              hit_line;

  // at most one way hits
  always_comb begin
    hit_way  = 1'b0;
    hit_line = '0;
    for (int w = 0; w < WAY_NUM; w++) begin
      if (hit_i[w]) begin
        hit_way  = 1'(w);
        hit_line = lines_i[w];
      end
    end
  end

  assign hit_o    = |hit_i;
  assign word_o   = hit_line[word_sel_i];
  assign victim_o = repl_q[s1_idx_i];

  // bit names the way that was not used last
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      repl_q <= '0;
    end else if (fill_i) begin
      repl_q[s1_idx_i] <= ~fill_way_i;
    end else if (touch_i) begin
      repl_q[s1_idx_i] <= ~hit_way;
    end
  end

endmodule

`default_nettype wire

// ==== design/icache_refill.sv ====
`default_nettype none

module icache_refill import icache_pkg::*; (
  input  wire logic              clk,
  input  wire logic              rst_n,
  input  wire logic              start_i,
  input  wire logic [ADDR_W-1:0] line_addr_i,
  // read address channel
  output logic                   ar_valid_o,
  output logic [ADDR_W-1:0]      ar_addr_o,
  output logic [7:0]             ar_len_o,
  input  wire logic              ar_ready_i,
  // read data channel
  input  wire logic              r_valid_i,
  input  wire word_t             r_data_i,
  input  wire logic              r_last_i,
  output logic                   r_ready_o,
  // to the controller
  output logic                   done_o,
  output line_t                  line_o
);

  typedef enum logic [1:0] {
    RF_IDLE,
    RF_ADDR,
    RF_DATA
  } rf_state_e;

  rf_state_e         state_q;
  logic [WSEL_W-1:0] beat_q;
  logic [ADDR_W-1:0] addr_q;
  line_t             line_q;
  logic              beat_fire;

  assign beat_fire  = (state_q == RF_DATA) && r_valid_i;
  assign done_o     = beat_fire && r_last_i;
  assign ar_valid_o = (state_q == RF_ADDR);
  assign ar_addr_o  = addr_q;
  assign ar_len_o   = 8'(LINE_WORDS - 1);
  assign r_ready_o  = (state_q == RF_DATA);
  assign line_o     = line_q;

  // ====================
  // burst FSM
  // ====================
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= RF_IDLE;
      beat_q  <= '0;
    end else begin
      case (state_q)
        RF_IDLE: begin
          beat_q <= '0;
          if (start_i) begin
            state_q <= RF_ADDR;
          end
        end
        RF_ADDR: begin
          if (ar_ready_i) begin
            state_q <= RF_DATA;
          end
        end
        RF_DATA: begin
          if (beat_fire) begin
            beat_q <= beat_q + 1'b1;
          end
          if (done_o) begin
            state_q <= RF_IDLE;
          end
        end
        default: state_q <= RF_IDLE;
      endcase
    end
  end

  // line assembly, beat k lands in word k
  always_ff @(posedge clk) begin
    if (start_i && (state_q == RF_IDLE)) begin
      addr_q <= line_addr_i;
    end
    if (beat_fire) begin
      line_q[beat_q] <= r_data_i;
    end
  end

endmodule

`default_nettype wire

// ==== design/icache_ctrl.sv ====
`default_nettype none

module icache_ctrl import icache_pkg::*; (
  input  wire logic              clk,
  input  wire logic              rst_n,
  // fetch side
  input  wire logic              req_valid_i,
  input  wire logic [ADDR_W-1:0] req_addr_i,
  output logic                   req_ready_o,
  output logic                   resp_valid_o,
  output word_t                  resp_data_o,
  output logic [ADDR_W-1:0]      resp_addr_o,
  output logic                   resp_err_o,
  input  wire logic              resp_ready_i,
  // flush and invalidate
  input  wire logic              flush_i,
  input  wire logic              inv_valid_i,
  output logic                   inv_ready_o,
  // lookup result
  input  wire logic              hit_i,
  input  wire word_t             word_i,
  input  wire logic              victim_i,
  // way controls
  output idx_t                   rd_idx_o,
  output tag_t                   cmp_tag_o,
  output logic [WAY_NUM-1:0]     way_we_o,
  output idx_t                   wr_idx_o,
  output tag_t                   wr_tag_o,
  output line_t                  wr_line_o,
  output logic                   inv_we_o,
  // replacement update
  output idx_t                   s1_idx_o,
  output logic [WSEL_W-1:0]      word_sel_o,
  output logic                   touch_o,
  output logic                   fill_o,
  output logic                   fill_way_o,
  // refill engine
  output logic                   refill_start_o,
  output logic [ADDR_W-1:0]      refill_addr_o,
  input  wire logic              refill_done_i,
  input  wire line_t             refill_line_i
);

  logic              run_q;
  logic              s1_valid_q;
  logic              s1_owns_q;
  logic              s1_filled_q;
  logic              fill_q;
  logic              busy_q;
  logic              s1_err_q;
  logic [ADDR_W-1:0] s1_addr_q;
  logic              s1_ready;
  logic              req_fire;
  logic              resp_fire;
  logic              miss;

  // ====================
  // stage 0
  // ====================
  assign s1_ready    = !s1_valid_q || resp_fire;
  assign inv_ready_o = run_q && s1_ready;
  assign inv_we_o    = inv_valid_i && inv_ready_o;
  // invalidate first, and nothing enters while flushing
  assign req_ready_o = run_q && s1_ready && !inv_valid_i && !flush_i;
  assign req_fire    = req_valid_i && req_ready_o;
  // hold the lookup on stage 1 while it waits
  assign rd_idx_o    = req_fire ? req_addr_i[OFS_W +: IDX_W] : s1_addr_q[OFS_W +: IDX_W];

  // ====================
  // stage 1
  // ====================
  assign s1_idx_o   = s1_addr_q[OFS_W +: IDX_W];
  assign cmp_tag_o  = s1_addr_q[ADDR_W-1 -: TAG_W];
  assign word_sel_o = s1_addr_q[OFS_W-1:2];

  assign miss         = s1_valid_q && !s1_err_q && !s1_filled_q && !hit_i;
  assign resp_valid_o = s1_valid_q && (s1_err_q || s1_filled_q || hit_i);
  assign resp_fire    = resp_valid_o && resp_ready_i;
  assign resp_addr_o  = s1_addr_q;
  assign resp_err_o   = s1_valid_q && s1_err_q;
  assign resp_data_o  = s1_err_q    ? '0 :
                        s1_filled_q ? refill_line_i[word_sel_o] : word_i;

  // one burst at a time, an orphaned one drains first
  assign refill_start_o = miss && !s1_owns_q && !busy_q && !flush_i;
  assign refill_addr_o  = {s1_addr_q[ADDR_W-1:OFS_W], {OFS_W{1'b0}}};

  // victim write, one cycle after the last beat
  always_comb begin
    for (int w = 0; w < WAY_NUM; w++) begin
      way_we_o[w] = fill_q && (victim_i == 1'(w));
    end
  end
  assign wr_idx_o   = s1_idx_o;
  assign wr_tag_o   = cmp_tag_o;
  assign wr_line_o  = refill_line_i;
  assign fill_o     = fill_q;
  assign fill_way_o = victim_i;
  assign touch_o    = resp_fire && hit_i && !s1_err_q && !s1_filled_q;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      run_q       <= 1'b0;
      s1_valid_q  <= 1'b0;
      s1_owns_q   <= 1'b0;
      s1_filled_q <= 1'b0;
      fill_q      <= 1'b0;
      busy_q      <= 1'b0;
    end else begin
      run_q  <= 1'b1;
      fill_q <= refill_done_i && s1_owns_q && !flush_i;
      if (refill_start_o) begin
        busy_q <= 1'b1;
      end else if (refill_done_i) begin
        busy_q <= 1'b0;
      end
      if (flush_i) begin
        s1_valid_q  <= 1'b0;
        s1_owns_q   <= 1'b0;
        s1_filled_q <= 1'b0;
      end else if (s1_ready) begin
        s1_valid_q  <= req_fire;
        s1_owns_q   <= 1'b0;
        s1_filled_q <= 1'b0;
      end else if (refill_start_o) begin
        s1_owns_q <= 1'b1;
      end else if (refill_done_i && s1_owns_q) begin
        s1_owns_q   <= 1'b0;
        s1_filled_q <= 1'b1;
      end
    end
  end

  // request payload and misaligned flag
  always_ff @(posedge clk) begin
    if (req_fire) begin
      s1_addr_q <= req_addr_i;
      s1_err_q  <= (req_addr_i[1:0] != 2'b00);
    end
  end

endmodule

`default_nettype wire

// ==== design/icache_top.sv ====
`default_nettype none

module icache_top import icache_pkg::*; (
  input  wire logic              clk,
  input  wire logic              rst_n,
  // fetch
  input  wire logic              req_valid_i,
  input  wire logic [ADDR_W-1:0] req_addr_i,
  output logic                   req_ready_o,
  output logic                   resp_valid_o,
  output word_t                  resp_data_o,
  output logic [ADDR_W-1:0]      resp_addr_o,
  output logic                   resp_err_o,
  input  wire logic              resp_ready_i,
  // control
  input  wire logic              flush_i,
  input  wire logic              inv_valid_i,
  input  wire idx_t              inv_idx_i,
  output logic                   inv_ready_o,
  // AXI read
  output logic                   ar_valid_o,
  output logic [ADDR_W-1:0]      ar_addr_o,
  output logic [7:0]             ar_len_o,
  input  wire logic              ar_ready_i,
  input  wire logic              r_valid_i,
  input  wire word_t             r_data_i,
  input  wire logic              r_last_i,
  output logic                   r_ready_o
);

  idx_t                rd_idx;
  idx_t                wr_idx;
  idx_t                s1_idx;
  tag_t                cmp_tag;
  tag_t                wr_tag;
  line_t               wr_line;
  line_t               refill_line;
  line_t [WAY_NUM-1:0] way_line;
  logic [WAY_NUM-1:0]  way_hit;
  logic [WAY_NUM-1:0]  way_we;
  logic [WSEL_W-1:0]   word_sel;
  logic [ADDR_W-1:0]   refill_addr;
  word_t               sel_word;
  logic                sel_hit;
  logic                victim;
  logic                inv_we;
  logic                touch;
  logic                fill;
  logic                fill_way;
  logic                refill_start;
  logic                refill_done;

  icache_ctrl u_ctrl (
    .clk, .rst_n,
    .req_valid_i, .req_addr_i, .req_ready_o,
    .resp_valid_o, .resp_data_o, .resp_addr_o, .resp_err_o, .resp_ready_i,
    .flush_i, .inv_valid_i, .inv_ready_o,
    .hit_i          (sel_hit),
    .word_i         (sel_word),
    .victim_i       (victim),
    .rd_idx_o       (rd_idx),
    .cmp_tag_o      (cmp_tag),
    .way_we_o       (way_we),
    .wr_idx_o       (wr_idx),
    .wr_tag_o       (wr_tag),
    .wr_line_o      (wr_line),
    .inv_we_o       (inv_we),
    .s1_idx_o       (s1_idx),
    .word_sel_o     (word_sel),
    .touch_o        (touch),
    .fill_o         (fill),
    .fill_way_o     (fill_way),
    .refill_start_o (refill_start),
    .refill_addr_o  (refill_addr),
    .refill_done_i  (refill_done),
    .refill_line_i  (refill_line)
  );

  for (genvar w = 0; w < WAY_NUM; w++) begin : gen_way
    icache_way u_way (
      .clk, .rst_n,
      .rd_idx_i  (rd_idx),
      .cmp_tag_i (cmp_tag),
      .we_i      (way_we[w]),
      .wr_idx_i  (wr_idx),
      .wr_tag_i  (wr_tag),
      .wr_line_i (wr_line),
      .inv_we_i  (inv_we),
      .inv_idx_i (inv_idx_i),
      .hit_o     (way_hit[w]),
      .line_o    (way_line[w])
    );
  end

  icache_way_select u_way_select (
    .clk, .rst_n,
    .hit_i      (way_hit),
    .lines_i    (way_line),
    .s1_idx_i   (s1_idx),
    .word_sel_i (word_sel),
    .touch_i    (touch),
    .fill_i     (fill),
    .fill_way_i (fill_way),
    .hit_o      (sel_hit),
    .word_o     (sel_word),
    .victim_o   (victim)
  );

  icache_refill u_refill (
    .clk, .rst_n,
    .start_i     (refill_start),
    .line_addr_i (refill_addr),
    .ar_valid_o, .ar_addr_o, .ar_len_o, .ar_ready_i,
    .r_valid_i, .r_data_i, .r_last_i, .r_ready_o,
    .done_o      (refill_done),
    .line_o      (refill_line)
  );

endmodule

`default_nettype wire

// ==== dv/icache_checker.sv ====
`default_nettype none

module icache_checker import icache_pkg::*; (
  input  wire logic              clk,
  input  wire logic              rst_n,
  input  wire logic              req_valid_i,
  input  wire logic [ADDR_W-1:0] req_addr_i,
  input  wire logic              req_ready_i,
  input  wire logic              resp_valid_i,
  input  wire word_t             resp_data_i,
  input  wire logic [ADDR_W-1:0] resp_addr_i,
  input  wire logic              resp_err_i,
  input  wire logic              resp_ready_i,
  input  wire logic              flush_i,
  input  wire logic              ar_valid_i,
  input  wire logic [ADDR_W-1:0] ar_addr_i,
  input  wire logic [7:0]        ar_len_i,
  input  wire logic              ar_ready_i,
  output int                     errors_o
);

  localparam word_t MEM_KEY = 32'hA5A5_0000;

  // accepted fetch addresses, oldest first
  logic [ADDR_W-1:0] pending [$];
  string             cur_name = "none";
  int                exp_refills = 0;
  int                refills = 0;
  int                test_errs = 0;
  int                errors = 0;

  assign errors_o = errors;

  function automatic void note_error();
    test_errs++;
    errors++;
  endfunction

  task automatic start_test(input string name, input int refills_exp);
    cur_name    = name;
    exp_refills = refills_exp;
    refills     = 0;
    test_errs   = 0;
  endtask

  task automatic finish_test();
    if (pending.size() != 0) begin
      $display("test %s: %0d responses never arrived", cur_name, pending.size());
      note_error();
    end
    if (refills != exp_refills) begin
      $display("Mismatch in %s: refills expected %0d, actual %0d",
               cur_name, exp_refills, refills);
      note_error();
    end
    if (test_errs == 0) begin
      $display("test %s passed with %0d refills", cur_name, refills);
    end else begin
      $display("test %s failed with %0d errors", cur_name, test_errs);
    end
    pending.delete();
  endtask

  // ====================
  // response compare
  // ====================
  task automatic check_resp();
    logic [ADDR_W-1:0] exp_addr;
    logic              exp_err;
    word_t             exp_data;
    if (pending.size() == 0) begin
      $display("test %s: response for %h came with no request pending",
               cur_name, resp_addr_i);
      note_error();
    end else begin
      exp_addr = pending.pop_front();
      exp_err  = (exp_addr[1:0] != 2'b00);
      // memory word is its own byte address xor the key
      exp_data = exp_err ? '0 : (exp_addr ^ MEM_KEY);
      if (resp_addr_i !== exp_addr) begin
        $display("Mismatch in %s: address expected %h, actual %h",
                 cur_name, exp_addr, resp_addr_i);
        note_error();
      end
      if (resp_err_i !== exp_err) begin
        $display("Mismatch in %s: error flag expected %b, actual %b",
                 cur_name, exp_err, resp_err_i);
        note_error();
      end
      if (resp_data_i !== exp_data) begin
        $display("Mismatch in %s: data expected %h, actual %h",
                 cur_name, exp_data, resp_data_i);
        note_error();
      end
    end
  endtask

  always @(posedge clk) begin
    if (rst_n) begin
      if (ar_valid_i && ar_ready_i) begin
        refills++;
        if ((ar_addr_i[OFS_W-1:0] != '0) || (ar_len_i != 8'(LINE_WORDS - 1))) begin
          $display("test %s: burst at %h with length %0d is not one aligned line",
                   cur_name, ar_addr_i, ar_len_i);
          note_error();
        end
      end
      if (resp_valid_i && resp_ready_i) begin
        check_resp();
      end
      // flush drops whatever stage 1 held
      if (flush_i) begin
        pending.delete();
      end
      if (req_valid_i && req_ready_i) begin
        pending.push_back(req_addr_i);
      end
    end
  end

endmodule

`default_nettype wire

// ==== dv/icache_assertions.sv ====
`default_nettype none

module icache_assertions import icache_pkg::*; (
  input wire logic              clk,
  input wire logic              rst_n,
  input wire logic              req_ready_i,
  input wire logic              resp_valid_i,
  input wire word_t             resp_data_i,
  input wire logic [ADDR_W-1:0] resp_addr_i,
  input wire logic              resp_ready_i,
  input wire logic              flush_i,
  input wire logic              ar_valid_i,
  input wire logic [ADDR_W-1:0] ar_addr_i,
  input wire logic              ar_ready_i,
  input wire logic              r_valid_i,
  input wire logic              r_ready_i
);

  int fails = 0;

  // quiet outputs in and right after reset
  reset_quiet: assert property (@(posedge clk)
    !rst_n |-> !ar_valid_i && !resp_valid_i && !req_ready_i)
    else begin fails++; $error("output active during reset"); end

  reset_exit: assert property (@(posedge clk)
    $rose(rst_n) |-> !ar_valid_i && !resp_valid_i && !r_ready_i)
    else begin fails++; $error("output active right after reset"); end

  // ====================
  // handshakes
  // ====================
  // a flush may empty stage 1
  resp_hold: assert property (@(posedge clk) disable iff (!rst_n)
    resp_valid_i && !resp_ready_i && !flush_i |=>
      resp_valid_i && $stable(resp_data_i) && $stable(resp_addr_i))
    else begin fails++; $error("response changed while stalled"); end

  ar_hold: assert property (@(posedge clk) disable iff (!rst_n)
    ar_valid_i && !ar_ready_i |=> ar_valid_i && $stable(ar_addr_i))
    else begin fails++; $error("read address changed before acceptance"); end

  r_taken: assert property (@(posedge clk) disable iff (!rst_n)
    r_valid_i |-> r_ready_i)
    else begin fails++; $error("read beat offered outside the refill"); end

endmodule

bind icache_top icache_assertions u_assert (
  .clk          (clk),
  .rst_n        (rst_n),
  .req_ready_i  (req_ready_o),
  .resp_valid_i (resp_valid_o),
  .resp_data_i  (resp_data_o),
  .resp_addr_i  (resp_addr_o),
  .resp_ready_i (resp_ready_i),
  .flush_i      (flush_i),
  .ar_valid_i   (ar_valid_o),
  .ar_addr_i    (ar_addr_o),
  .ar_ready_i   (ar_ready_i),
  .r_valid_i    (r_valid_i),
  .r_ready_i    (r_ready_o)
);

`default_nettype wire

// ==== dv/icache_tb.sv ====
`default_nettype none

module icache_tb import icache_pkg::*; ();

  localparam int    NUM_TESTS  = 14;
  localparam int    MAX_CYCLES = NUM_TESTS * 40;
  localparam word_t MEM_KEY    = 32'hA5A5_0000;

  typedef enum {OP_FETCH, OP_INV, OP_FLUSH, OP_STREAM} op_e;

  typedef struct {
    string             name;
    op_e               op;
    logic [ADDR_W-1:0] addr;
    int                refills;
  } entry_t;

  logic              clk;
  logic              rst_n;
  logic              req_valid_i;
  logic [ADDR_W-1:0] req_addr_i;
  logic              req_ready_o;
  logic              resp_valid_o;
  word_t             resp_data_o;
  logic [ADDR_W-1:0] resp_addr_o;
  logic              resp_err_o;
  logic              resp_ready_i;
  logic              flush_i;
  logic              inv_valid_i;
  idx_t              inv_idx_i;
  logic              inv_ready_o;
  logic              ar_valid_o;
  logic [ADDR_W-1:0] ar_addr_o;
  logic [7:0]        ar_len_o;
  logic              ar_ready_i;
  logic              r_valid_i;
  word_t             r_data_i;
  logic              r_last_i;
  logic              r_ready_o;

  entry_t tests [NUM_TESTS];
  integer seed = 15;
  int     cycles = 0;
  int     chk_errors;
  logic   bp_on;
  logic   bp_now;
  logic   [31:0] bp_draw;
  logic   req_hs;
  logic   resp_hs;
  logic   inv_hs;
  logic   last_hs;

  icache_top u_dut (.*);

  icache_checker u_chk (
    .clk, .rst_n,
    .req_valid_i, .req_addr_i,
    .req_ready_i  (req_ready_o),
    .resp_valid_i (resp_valid_o),
    .resp_data_i  (resp_data_o),
    .resp_addr_i  (resp_addr_o),
    .resp_err_i   (resp_err_o),
    .resp_ready_i, .flush_i,
    .ar_valid_i   (ar_valid_o),
    .ar_addr_i    (ar_addr_o),
    .ar_len_i     (ar_len_o),
    .ar_ready_i,
    .errors_o     (chk_errors)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // handshake flags sampled on the edge and the cycle limit
  always @(posedge clk) begin
    cycles++;
    req_hs  = req_valid_i && req_ready_o;
    resp_hs = resp_valid_o && resp_ready_i;
    inv_hs  = inv_valid_i && inv_ready_o;
    last_hs = r_valid_i && r_ready_o && r_last_i;
    if (cycles >= MAX_CYCLES) begin
      $display("timeout: run did not end within %0d cycles", MAX_CYCLES);
      $display("Checks failed");
      $finish;
    end
  end

  // random response back-pressure drawn on the edge
  always @(posedge clk) begin
    bp_draw = $random(seed);
    bp_now  = bp_on;
    #1;
    resp_ready_i = bp_now ? bp_draw[0] : 1'b1;
  end

  task automatic step();
    @(posedge clk);
    #1;
  endtask

  // ====================
  // AXI memory model
  // ====================
  initial begin : axi_slave
    logic [ADDR_W-1:0] base;
    int                beats;
    int                gap;
    @(posedge rst_n);
    forever begin
      step();
      if (ar_valid_o) begin
        base  = ar_addr_o;
        beats = ar_len_o + 1;
        gap   = $random(seed) & 3;
        repeat (gap) step();
        ar_ready_i = 1'b1;
        step();
        ar_ready_i = 1'b0;
        for (int b = 0; b < beats; b++) begin
          gap = $random(seed) & 3;
          repeat (gap) step();
          r_valid_i = 1'b1;
          r_data_i  = (base + ADDR_W'(4 * b)) ^ MEM_KEY;
          r_last_i  = (b == beats - 1);
          step();
          r_valid_i = 1'b0;
          r_last_i  = 1'b0;
        end
      end
    end
  end

  task automatic fetch_one(input logic [ADDR_W-1:0] addr);
    req_valid_i = 1'b1;
    req_addr_i  = addr;
    step();
    while (!req_hs) step();
    req_valid_i = 1'b0;
    while (!resp_hs) step();
  endtask

  task automatic invalidate_set(input idx_t idx);
    inv_valid_i = 1'b1;
    inv_idx_i   = idx;
    step();
    while (!inv_hs) step();
    inv_valid_i = 1'b0;
  endtask

  // flush once the burst is issued, then let it drain
  task automatic flush_refill(input logic [ADDR_W-1:0] addr);
    req_valid_i = 1'b1;
    req_addr_i  = addr;
    step();
    while (!req_hs) step();
    req_valid_i = 1'b0;
    while (!ar_valid_o) step();
    flush_i = 1'b1;
    step();
    flush_i = 1'b0;
    while (!last_hs) step();
  endtask

  task automatic fetch_stream(input logic [ADDR_W-1:0] addr, input int count);
    int sent;
    int got;
    sent        = 0;
    got         = 0;
    bp_on       = 1'b1;
    req_valid_i = 1'b1;
    req_addr_i  = addr;
    while (got < count) begin
      step();
      if (resp_hs) got++;
      if (req_hs) begin
        sent++;
        if (sent < count) begin
          req_addr_i = addr + ADDR_W'(4 * sent);
        end else begin
          req_valid_i = 1'b0;
        end
      end
    end
    bp_on = 1'b0;
  endtask

  // name, operation, address or set index, expected bursts
  function automatic void load_tests();
    tests[0]  = '{"cold_fetch",          OP_FETCH,  32'h0000_1004, 1};
    tests[1]  = '{"same_line",           OP_FETCH,  32'h0000_100C, 0};
    tests[2]  = '{"misaligned",          OP_FETCH,  32'h0000_7002, 0};
    tests[3]  = '{"repl_a",              OP_FETCH,  32'h0000_2030, 1};
    tests[4]  = '{"repl_b",              OP_FETCH,  32'h0000_3030, 1};
    tests[5]  = '{"repl_c",              OP_FETCH,  32'h0000_4034, 1};
    tests[6]  = '{"repl_a_again",        OP_FETCH,  32'h0000_2038, 1};
    tests[7]  = '{"repl_c_hit",          OP_FETCH,  32'h0000_4030, 0};
    tests[8]  = '{"inv_set0",            OP_INV,    32'h0000_0000, 0};
    tests[9]  = '{"refetch_after_inv",   OP_FETCH,  32'h0000_1008, 1};
    tests[10] = '{"flush_mid_refill",    OP_FLUSH,  32'h0000_5050, 1};
    tests[11] = '{"refetch_after_flush", OP_FETCH,  32'h0000_5050, 1};
    tests[12] = '{"stream_backpressure", OP_STREAM, 32'h0000_6060, 2};
    tests[13] = '{"stream_hits",         OP_STREAM, 32'h0000_6060, 0};
  endfunction

  // ====================
  // main sequence
  // ====================
  initial begin : main
    int total;
    rst_n        = 1'b0;
    req_valid_i  = 1'b0;
    req_addr_i   = '0;
    resp_ready_i = 1'b1;
    flush_i      = 1'b0;
    inv_valid_i  = 1'b0;
    inv_idx_i    = '0;
    ar_ready_i   = 1'b0;
    r_valid_i    = 1'b0;
    r_data_i     = '0;
    r_last_i     = 1'b0;
    bp_on        = 1'b0;
    load_tests();
    repeat (8) @(posedge clk);
    #1;
    rst_n = 1'b1;
    step();
    for (int t = 0; t < NUM_TESTS; t++) begin
      u_chk.start_test(tests[t].name, tests[t].refills);
      case (tests[t].op)
        OP_FETCH: fetch_one(tests[t].addr);
        OP_INV:   invalidate_set(tests[t].addr[IDX_W-1:0]);
        OP_FLUSH: flush_refill(tests[t].addr);
        default:  fetch_stream(tests[t].addr, 2 * LINE_WORDS);
      endcase
      // room for a stray response to show up
      repeat (2) step();
      u_chk.finish_test();
    end
    total = chk_errors + u_dut.u_assert.fails;
    $display("%0d tests run, %0d errors", NUM_TESTS, total);
    if (total == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== icache_top.f ====
design/icache_pkg.sv
design/icache_sdp_ram.sv
design/icache_way.sv
design/icache_way_select.sv
design/icache_refill.sv
design/icache_ctrl.sv
design/icache_top.sv
dv/icache_checker.sv
dv/icache_assertions.sv
dv/icache_tb.sv
